// File: verilog/sram_pkg.sv
package sram_pkg;

  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int STRB_W       = 4;
  localparam int MEM_WORDS    = 1024;
  localparam int MEM_BYTES    = MEM_WORDS * STRB_W;  // valid byte range is 0 to 4095.
  localparam int IDX_W        = $clog2(MEM_WORDS);
  localparam int BYTE_LSB     = $clog2(STRB_W);      // word index starts above the byte lanes.
  localparam int DELAY_MIN    = 2;
  localparam int DELAY_MASK_W = 3;
  localparam int CNT_W        = 4;                   // holds DELAY_MIN - 1 + 7 at most.
  localparam int LFSR_W       = 8;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 8'h5A;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 8'hB8;   // x^8 + x^6 + x^5 + x^4 + 1.

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              err;
  } rd_resp_t;

  typedef struct packed {
    logic err;
  } wr_resp_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_PENDING,
    RD_WAIT_RESP
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_DATA,
    WR_PENDING,
    WR_WAIT_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_COUNT_RD,
    CORE_COUNT_WR
  } core_state_e;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } core_op_e;

endpackage

// File: verilog/lfsr_delay.sv
`timescale 1ns/1ps

module lfsr_delay import sram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  output logic [LFSR_W-1:0] lfsr_value
);

  logic [LFSR_W-1:0] lfsr_q;
  logic [LFSR_W-1:0] lfsr_next;

  // Galois form, so the feedback bit is xored into the tap positions in parallel.
  always_comb begin
    lfsr_next = {1'b0, lfsr_q[LFSR_W-1:1]};
    if (lfsr_q[0]) begin
      lfsr_next = lfsr_next ^ LFSR_TAPS;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= LFSR_SEED;  // must be nonzero or the register locks up.
    end else begin
      lfsr_q <= lfsr_next;
    end
  end

  assign lfsr_value = lfsr_q;

endmodule

// File: verilog/axi_req_capture.sv
`timescale 1ns/1ps

module axi_req_capture import sram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              awready,
  output logic              wready,
  output rd_req_t           rd_req,
  output logic              rd_pending,
  output wr_req_t           wr_req,
  output logic              wr_pending,
  input  logic              rd_take,
  input  logic              wr_take,
  input  logic              rd_free,
  input  logic              wr_free
);

  rd_state_e rd_state;
  wr_state_e wr_state;

  // the read side keeps one request in flight between address accept and rd_free.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state   <= RD_IDLE;
      arready    <= 1'b1;
      rd_pending <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (arvalid && arready) begin
            arready    <= 1'b0;
            rd_pending <= 1'b1;
            rd_state   <= RD_PENDING;
          end
        end
        RD_PENDING: begin
          if (rd_take) begin
            rd_pending <= 1'b0;
            rd_state   <= RD_WAIT_RESP;
          end
        end
        RD_WAIT_RESP: begin
          if (rd_free) begin
            arready  <= 1'b1;  // reopen only once the master has the data.
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rd_req.addr <= araddr;
    end
  end

  // the write side takes the address first and then the data beat.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state   <= WR_IDLE;
      awready    <= 1'b1;
      wready     <= 1'b0;
      wr_pending <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (awvalid && awready) begin
            awready  <= 1'b0;
            wready   <= 1'b1;
            wr_state <= WR_WAIT_DATA;
          end
        end
        WR_WAIT_DATA: begin
          if (wvalid && wready) begin
            wready     <= 1'b0;
            wr_pending <= 1'b1;
            wr_state   <= WR_PENDING;
          end
        end
        WR_PENDING: begin
          if (wr_take) begin
            wr_pending <= 1'b0;
            wr_state   <= WR_WAIT_RESP;
          end
        end
        WR_WAIT_RESP: begin
          if (wr_free) begin
            awready  <= 1'b1;
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      wr_req.addr <= awaddr;
    end
    if (wvalid && wready) begin
      wr_req.data <= wdata;
      wr_req.strb <= wstrb;
    end
  end

endmodule

// File: verilog/sram_core.sv
`timescale 1ns/1ps

module sram_core import sram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  rd_req_t           rd_req,
  input  logic              rd_pending,
  input  wr_req_t           wr_req,
  input  logic              wr_pending,
  input  logic [LFSR_W-1:0] lfsr_value,
  output logic              rd_take,
  output logic              wr_take,
  output logic              rd_done,
  output rd_resp_t          rd_resp,
  output logic              wr_done,
  output wr_resp_t          wr_resp
);

  logic [DATA_W-1:0] mem [MEM_WORDS];

  core_state_e       state;
  core_op_e          next_op;
  wr_req_t           cur_req;
  logic [CNT_W-1:0]  count;
  logic [IDX_W-1:0]  mem_idx;
  logic              in_range;

  // reads win when both directions are waiting.
  assign next_op = rd_pending ? OP_READ : OP_WRITE;
  assign rd_take = (state == CORE_IDLE) && rd_pending;
  assign wr_take = (state == CORE_IDLE) && wr_pending && !rd_pending;

  assign rd_done = (state == CORE_COUNT_RD) && (count == '0);
  assign wr_done = (state == CORE_COUNT_WR) && (count == '0);

  assign mem_idx  = cur_req.addr[IDX_W+BYTE_LSB-1:BYTE_LSB];
  assign in_range = cur_req.addr < ADDR_W'(MEM_BYTES);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CORE_IDLE;
      count <= '0;
    end else begin
      case (state)
        CORE_IDLE: begin
          if (rd_take || wr_take) begin
            // take to done is DELAY_MIN plus the random part.
            count <= CNT_W'(DELAY_MIN - 1) + CNT_W'(lfsr_value[DELAY_MASK_W-1:0]);
            state <= (next_op == OP_READ) ? CORE_COUNT_RD : CORE_COUNT_WR;
          end
        end
        CORE_COUNT_RD, CORE_COUNT_WR: begin
          if (count == '0) begin
            state <= CORE_IDLE;
          end else begin
            count <= count - 1'b1;
          end
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  // the request is copied at the take so the capture side is free to move on.
  always_ff @(posedge clk) begin
    if (rd_take) begin
      cur_req.addr <= rd_req.addr;
      cur_req.data <= '0;
      cur_req.strb <= '0;
    end else if (wr_take) begin
      cur_req <= wr_req;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_done && in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (cur_req.strb[b]) begin
          mem[mem_idx][b*8 +: 8] <= cur_req.data[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    rd_resp.data = in_range ? mem[mem_idx] : '0;  // a faulted read returns zero.
    rd_resp.err  = !in_range;
    wr_resp.err  = !in_range;
  end

endmodule

// File: verilog/axi_resp_drive.sv
`timescale 1ns/1ps

module axi_resp_drive import sram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_done,
  input  rd_resp_t          rd_resp,
  input  logic              wr_done,
  input  wr_resp_t          wr_resp,
  output logic [DATA_W-1:0] rdata,
  output logic              rresp,
  output logic              rvalid,
  input  logic              rready,
  output logic              bresp,
  output logic              bvalid,
  input  logic              bready,
  output logic              rd_free,
  output logic              wr_free
);

  rd_resp_t rd_hold;
  wr_resp_t wr_hold;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid  <= 1'b0;
      rd_free <= 1'b0;
    end else begin
      rd_free <= 1'b0;
      if (rd_done) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid  <= 1'b0;
        rd_free <= 1'b1;  // lets the capture side take the next read address.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid  <= 1'b0;
      wr_free <= 1'b0;
    end else begin
      wr_free <= 1'b0;
      if (wr_done) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid  <= 1'b0;
        wr_free <= 1'b1;
      end
    end
  end

  // payload only loads on done, so it stays put while the master stalls.
  always_ff @(posedge clk) begin
    if (rd_done) begin
      rd_hold <= rd_resp;
    end
    if (wr_done) begin
      wr_hold <= wr_resp;
    end
  end

  assign rdata = rd_hold.data;
  assign rresp = rd_hold.err;
  assign bresp = wr_hold.err;

endmodule

// File: verilog/sram_axi_top.sv
`timescale 1ns/1ps

module sram_axi_top import sram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output logic              rresp,
  output logic              rvalid,
  input  logic              rready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic              bresp,
  output logic              bvalid,
  input  logic              bready
);

  rd_req_t           rd_req;
  wr_req_t           wr_req;
  rd_resp_t          rd_resp;
  wr_resp_t          wr_resp;
  logic              rd_pending;
  logic              wr_pending;
  logic              rd_take;
  logic              wr_take;
  logic              rd_done;
  logic              wr_done;
  logic              rd_free;
  logic              wr_free;
  logic [LFSR_W-1:0] lfsr_value;

  axi_req_capture i_capture (
    .clk        (clk),
    .rst        (rst),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .awready    (awready),
    .wready     (wready),
    .rd_req     (rd_req),
    .rd_pending (rd_pending),
    .wr_req     (wr_req),
    .wr_pending (wr_pending),
    .rd_take    (rd_take),
    .wr_take    (wr_take),
    .rd_free    (rd_free),
    .wr_free    (wr_free)
  );

  sram_core i_core (
    .clk        (clk),
    .rst        (rst),
    .rd_req     (rd_req),
    .rd_pending (rd_pending),
    .wr_req     (wr_req),
    .wr_pending (wr_pending),
    .lfsr_value (lfsr_value),
    .rd_take    (rd_take),
    .wr_take    (wr_take),
    .rd_done    (rd_done),
    .rd_resp    (rd_resp),
    .wr_done    (wr_done),
    .wr_resp    (wr_resp)
  );

  lfsr_delay i_lfsr (
    .clk        (clk),
    .rst        (rst),
    .lfsr_value (lfsr_value)
  );

  axi_resp_drive i_resp (
    .clk     (clk),
    .rst     (rst),
    .rd_done (rd_done),
    .rd_resp (rd_resp),
    .wr_done (wr_done),
    .wr_resp (wr_resp),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .rd_free (rd_free),
    .wr_free (wr_free)
  );

endmodule

// File: sim/tb_sram_axi.sv
`timescale 1ns/1ps

module tb_sram_axi import sram_pkg::*; ();

  typedef struct packed {
    logic [7:0] op;
    logic       both;
    wr_req_t    req;
    rd_resp_t   exp;
  } test_t;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic              rresp;
  logic              rvalid;
  logic              rready;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic              bresp;
  logic              bvalid;
  logic              bready;

  test_t tests[$];
  int    seed = 80;
  int    n_tests;
  bit    loaded;

  sram_axi_top i_dut (.*);

  always #4 clk = ~clk;

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic send_read(input logic [ADDR_W-1:0] addr);
    araddr  = addr;
    arvalid = 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  // the address beat goes first and the data beat follows once wready opens.
  task automatic send_write(input wr_req_t req);
    awaddr  = req.addr;
    awvalid = 1'b1;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wdata   = req.data;
    wstrb   = req.strb;
    wvalid  = 1'b1;
    do @(negedge clk); while (!wready);
    @(posedge clk);
    #1;
    wvalid = 1'b0;
  endtask

  task automatic take_read(input rd_resp_t exp, input int stalls);
    do @(negedge clk); while (!rvalid);
    check_equal("rdata", exp.data, rdata);
    check_equal("rresp", 32'(exp.err), 32'(rresp));
    repeat (stalls + 1) begin
      @(negedge clk);  // payload must hold while rready is low.
      check_equal("rvalid", 32'h1, 32'(rvalid));
      check_equal("rdata", exp.data, rdata);
      check_equal("rresp", 32'(exp.err), 32'(rresp));
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
    @(negedge clk);
    check_equal("rvalid", 32'h0, 32'(rvalid));  // one response per request.
  endtask

  task automatic take_write(input logic exp_err, input int stalls);
    do @(negedge clk); while (!bvalid);
    check_equal("bresp", 32'(exp_err), 32'(bresp));
    repeat (stalls + 1) begin
      @(negedge clk);
      check_equal("bvalid", 32'h1, 32'(bvalid));
      check_equal("bresp", 32'(exp_err), 32'(bresp));
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
    @(negedge clk);
    check_equal("bvalid", 32'h0, 32'(bvalid));
  endtask

  initial begin
    int          fd;
    int          n;
    int          rd_stall;
    int          wr_stall;
    string       line;
    logic [7:0]  op_c;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [3:0]  s;
    logic        er;
    logic        bo;
    test_t       t;
    clk     = 1'b0;
    rst     = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    fd = $fopen("sim/sram_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file sim/sram_tests.txt");
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%c %h %h %h %h %h %h", op_c, a, d, s, e, er, bo);
      if (n != 7 || (op_c != "R" && op_c != "W")) begin
        $display("the test file has a malformed line: %s", line);
        stop_with_failure();
      end
      t.op       = op_c;
      t.both     = bo;
      t.req.addr = a;
      t.req.data = d;
      t.req.strb = s;
      t.exp.data = e;
      t.exp.err  = er;
      tests.push_back(t);
    end
    $fclose(fd);
    n_tests = tests.size();
    if (n_tests == 0) begin
      $display("the test file holds no tests");
      stop_with_failure();
    end
    loaded = 1'b1;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_equal("arready", 32'h1, 32'(arready));
    check_equal("awready", 32'h1, 32'(awready));
    check_equal("wready", 32'h0, 32'(wready));
    check_equal("rvalid", 32'h0, 32'(rvalid));
    check_equal("bvalid", 32'h0, 32'(bvalid));

    foreach (tests[i]) begin
      rd_stall = $random(seed) & 3;
      wr_stall = $random(seed) & 3;
      @(posedge clk);
      #1;
      if (tests[i].op == "R") begin
        send_read(tests[i].req.addr);
        take_read(tests[i].exp, rd_stall);
      end else if (tests[i].both) begin
        fork  // read and write addresses go out in the same cycle.
          begin
            send_read(tests[i].req.addr);
            take_read(tests[i].exp, rd_stall);
          end
          begin
            send_write(tests[i].req);
            take_write(tests[i].exp.err, wr_stall);
          end
        join
      end else begin
        send_write(tests[i].req);
        take_write(tests[i].exp.err, wr_stall);
      end
    end
    $display("** PASS **");
    $finish;
  end

  initial begin
    wait (loaded);
    #(n_tests * 40 * 8);
    $display("timeout, the DUT stopped answering before all tests were done");
    stop_with_failure();
  end

endmodule

// File: sim/sram_tests.txt
# op addr wdata strb exp_rdata exp_err both, all values in hex
# both=1 on a W line also issues a read of the same address in the same cycle
W 00000000 11223344 f 00000000 0 0
R 00000000 00000000 0 11223344 0 0
W 00000004 a5a5a5a5 f 00000000 0 0
W 00000004 000000cc 1 00000000 0 0
W 00000004 dd000000 8 00000000 0 0
R 00000004 00000000 0 dda5a5cc 0 0
W 00000004 00beef00 6 00000000 0 0
R 00000004 00000000 0 ddbeefcc 0 0
W 00000ffc cafef00d f 00000000 0 0
R 00000ffc 00000000 0 cafef00d 0 0
W 00001000 ffffffff f 00000000 1 0
R 00001000 00000000 0 00000000 1 0
R 00000000 00000000 0 11223344 0 0
W 00001ffc 12345678 f 00000000 1 0
R 00000ffc 00000000 0 cafef00d 0 0
R 80000004 00000000 0 00000000 1 0
W 00000008 0badf00d f 00000000 0 0
W 00000008 deadbeef f 0badf00d 0 1
R 00000008 00000000 0 deadbeef 0 0
W 00000000 00005500 2 00000000 0 0
W 00000000 99887766 f 11225544 0 1
R 00000000 00000000 0 99887766 0 0

// File: filelist.f
verilog/sram_pkg.sv
verilog/lfsr_delay.sv
verilog/axi_req_capture.sv
verilog/sram_core.sv
verilog/axi_resp_drive.sv
verilog/sram_axi_top.sv
sim/tb_sram_axi.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_sram_axi -f filelist.f -o tb_sram_axi

./obj_dir/tb_sram_axi > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
